/* all.f */
+incdir+bench
source/fm_pkg.sv
source/fm_timer.sv
source/fm_regs.sv
source/fm_timers.sv
source/fm_top.sv
bench/fm_top_tb.sv

/* bench/fm_tb_checks.svh */
// Address phase then data phase, one cycle each
task automatic bus_write(input logic [7:0] reg_addr, input logic [7:0] data, input logic bank);
	@(negedge clk);
	cs_n = 1'b0;
	wr_n = 1'b0;
	addr = {bank, 1'b0};
	din  = reg_addr;
	@(negedge clk);
	addr = {bank, 1'b1};
	din  = data;
	@(negedge clk);
	cs_n = 1'b1;
	wr_n = 1'b1;
	// Busy is up one cycle after the data write
	if (dout[7] !== 1'b1) begin
		stop_on_error($sformatf("[ERROR] busy: got %h expected %h", dout[7], 1'b1));
	end
endtask

// Busy lasts BUSY_TICKS internal enables, one enable per CEN_DIV clocks
task automatic wait_busy_low(inout int cycles);
	int lo_limit;
	int hi_limit;
	lo_limit = (BUSY_TICKS - 1) * CEN_DIV;
	hi_limit = (BUSY_TICKS + 1) * CEN_DIV;
	while (dout[7] !== 1'b0) begin
		if (cycles >= hi_limit) begin
			stop_on_error($sformatf("busy still high %0d cycles after the data write", cycles));
		end
		@(negedge clk);
		cycles++;
	end
	if (cycles < lo_limit) begin
		stop_on_error($sformatf("busy fell after only %0d cycles", cycles));
	end
endtask

task automatic expect_flag_window(inout int cycles, input int lo_limit, input int hi_limit);
	while (dout[1:0] === 2'b00) begin
		if (cycles >= hi_limit) begin
			stop_on_error($sformatf("no timer flag within %0d cycles of the load write", cycles));
		end
		@(negedge clk);
		cycles++;
	end
	if (cycles < lo_limit) begin
		stop_on_error($sformatf("timer flag set after %0d cycles, before %0d", cycles, lo_limit));
	end
endtask

task automatic check_status(input status_t exp);
	status_t got;
	got = status_t'({dout[7], dout[1], dout[0]});
	if (got !== exp) begin
		stop_on_error($sformatf("[ERROR] status: got %h expected %h", got, exp));
	end
	// Unused status bits
	if (dout[6:2] !== 5'd0) begin
		stop_on_error($sformatf("[ERROR] dout[6:2]: got %h expected %h", dout[6:2], 5'd0));
	end
endtask

task automatic check_irq(input logic exp);
	if (irq_n !== exp) begin
		stop_on_error($sformatf("[ERROR] irq_n: got %h expected %h", irq_n, exp));
	end
endtask

/* bench/fm_top_tb.sv */
`timescale 1ns/1ps

module fm_top_tb
	import fm_pkg::*;
();

	typedef enum logic [1:0] {
		CHK_NOW,
		CHK_FLAG,
		CHK_QUIET
	} check_kind_t;

	// One bus write and what the status must do after it
	typedef struct packed {
		logic [7:0]  reg_addr;
		logic [7:0]  data;
		logic        bank;
		check_kind_t kind;
		status_t     exp_status;
		logic        exp_irq;
		int          win_lo;
		int          win_hi;
	} row_t;

	logic       clk;
	logic       reset;
	logic       cen;
	logic       cs_n;
	logic       wr_n;
	logic [7:0] din;
	logic [1:0] addr;
	logic [7:0] dout;
	logic       irq_n;

	row_t       rows[$];
	integer     seed = 32'h302e;

	fm_top dut0 (
		.clk   ( clk   ),
		.reset ( reset ),
		.cen   ( cen   ),
		.cs_n  ( cs_n  ),
		.wr_n  ( wr_n  ),
		.din   ( din   ),
		.addr  ( addr  ),
		.dout  ( dout  ),
		.irq_n ( irq_n )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	`include "fm_tb_checks.svh"

	task automatic add_row(input logic [7:0] reg_addr, input logic [7:0] data, input logic bank,
			input check_kind_t kind, input status_t exp_status, input logic exp_irq,
			input int win_lo, input int win_hi);
		row_t r;
		r.reg_addr   = reg_addr;
		r.data       = data;
		r.bank       = bank;
		r.kind       = kind;
		r.exp_status = exp_status;
		r.exp_irq    = exp_irq;
		r.win_lo     = win_lo;
		r.win_hi     = win_hi;
		rows.push_back(r);
	endtask

	initial begin
		row_t       row;
		int         cycles;
		int         ta_ticks;
		int         tb_ticks;
		int         quiet_ticks;
		logic [9:0] value_a;
		logic [7:0] value_b;
		reset = 1'b1;
		cen   = 1'b1;
		cs_n  = 1'b1;
		wr_n  = 1'b1;
		din   = 8'h00;
		addr  = 2'b00;

		// Short periods, but timer A outlasts busy
		value_a     = 10'(1014 - ($unsigned($random(seed)) % 8));
		value_b     = 8'(255 - ($unsigned($random(seed)) % 3));
		ta_ticks    = 1024 - value_a;
		tb_ticks    = (256 - value_b) * TIMER_B_DIV;
		quiet_ticks = 2 * (tb_ticks + TIMER_B_DIV);

		add_row(REG_TEST, 8'h04, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		add_row(REG_TA_HI, value_a[9:2], 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		add_row(REG_TA_LO, {6'd0, value_a[1:0]}, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		add_row(REG_TB, value_b, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		// Timer A run, then clear
		add_row(REG_TIMER_CTL, 8'h05, 1'b0, CHK_FLAG, 3'b001, 1'b0, ta_ticks, ta_ticks + 1);
		add_row(REG_TIMER_CTL, 8'h10, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		// Timer B run, then clear
		add_row(REG_TIMER_CTL, 8'h0a, 1'b0, CHK_FLAG, 3'b010, 1'b0,
			tb_ticks, tb_ticks + TIMER_B_DIV);
		add_row(REG_TIMER_CTL, 8'h20, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);
		// Both running, interrupts off
		add_row(REG_TIMER_CTL, 8'h03, 1'b0, CHK_QUIET, 3'b000, 1'b1, 0, quiet_ticks);
		// Interrupts on, both stopped
		add_row(REG_TIMER_CTL, 8'h0c, 1'b0, CHK_QUIET, 3'b000, 1'b1, 0, quiet_ticks);
		// Bank 1 writes go nowhere
		add_row(REG_TIMER_CTL, 8'h0f, 1'b1, CHK_QUIET, 3'b000, 1'b1, 0, quiet_ticks);
		add_row(REG_TA_HI, 8'h00, 1'b1, CHK_NOW, 3'b000, 1'b1, 0, 0);
		add_row(REG_TB, 8'h00, 1'b1, CHK_NOW, 3'b000, 1'b1, 0, 0);
		// Periods still come from the bank 0 values
		add_row(REG_TIMER_CTL, 8'h05, 1'b0, CHK_FLAG, 3'b001, 1'b0, ta_ticks, ta_ticks + 1);
		add_row(REG_TIMER_CTL, 8'h1a, 1'b0, CHK_FLAG, 3'b010, 1'b0,
			tb_ticks, tb_ticks + TIMER_B_DIV);
		add_row(REG_TIMER_CTL, 8'h20, 1'b0, CHK_NOW, 3'b000, 1'b1, 0, 0);

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_status(3'b000);
		check_irq(1'b1);

		foreach (rows[i]) begin
			row = rows[i];
			bus_write(row.reg_addr, row.data, row.bank);
			cycles = 0;
			wait_busy_low(cycles);
			if (row.kind == CHK_FLAG) begin
				check_status(3'b000);
				// Tick phase at the write is unknown, so allow one tick early
				expect_flag_window(cycles, (row.win_lo - 1) * SAMPLE_DIV,
					row.win_hi * SAMPLE_DIV + 2);
			end else if (row.kind == CHK_QUIET) begin
				while (cycles < row.win_hi * SAMPLE_DIV) begin
					@(negedge clk);
					cycles++;
					check_status(3'b000);
				end
			end
			check_status(row.exp_status);
			check_irq(row.exp_irq);
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

/* source/fm_top.sv */
`timescale 1ns/1ps

module fm_top
	import fm_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cen,
	input  logic       cs_n,
	input  logic       wr_n,
	input  logic [7:0] din,
	input  logic [1:0] addr,
	output logic [7:0] dout,
	output logic       irq_n
);

	logic       write;
	timer_cfg_t cfg;
	logic       sample_tick;
	logic       busy;

	// CPU write strobe
	assign write = ~cs_n & ~wr_n;

	fm_regs u_regs (
		.clk         ( clk         ),
		.reset       ( reset       ),
		.cen         ( cen         ),
		.din         ( din         ),
		.addr        ( addr        ),
		.write       ( write       ),
		.cfg         ( cfg         ),
		// Internal enable, only the sound pipelines would use it here
		.clk_en      (             ),
		.sample_tick ( sample_tick ),
		.busy        ( busy        )
	);

	fm_timers u_timers (
		.clk         ( clk         ),
		.reset       ( reset       ),
		.cfg         ( cfg         ),
		.sample_tick ( sample_tick ),
		.busy        ( busy        ),
		.dout        ( dout        ),
		.irq_n       ( irq_n       )
	);

endmodule

/* source/fm_timers.sv */
`timescale 1ns/1ps

module fm_timers
	import fm_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  timer_cfg_t cfg,
	input  logic       sample_tick,
	input  logic       busy,
	output logic [7:0] dout,
	output logic       irq_n
);

	logic                tick_b;
	logic [TB_DIV_W-1:0] tb_div;
	logic                load_b_q;
	logic                load_b_rise;
	logic                flag_a;
	logic                flag_b;
	status_t             status;

	assign load_b_rise = cfg.load_b & ~load_b_q;

	// Timer B prescaler, realigned when timer B starts
	always_ff @(posedge clk) begin
		if (reset) begin
			load_b_q <= 1'b0;
			tb_div   <= '0;
		end else begin
			load_b_q <= cfg.load_b;
			if (load_b_rise) begin
				tb_div <= '0;
			end else if (sample_tick) begin
				tb_div <= (tb_div == TB_DIV_W'(TIMER_B_DIV - 1)) ? '0 : tb_div + 1'b1;
			end
		end
	end

	assign tick_b = sample_tick & (tb_div == TB_DIV_W'(TIMER_B_DIV - 1));

	fm_timer #(
		.WIDTH  ( TA_W         )
	) u_timer_a (
		.clk    ( clk          ),
		.reset  ( reset        ),
		.tick   ( sample_tick  ),
		.load   ( cfg.load_a   ),
		.irq_en ( cfg.irq_en_a ),
		.clr    ( cfg.clr_a    ),
		.value  ( cfg.value_a  ),
		.flag   ( flag_a       )
	);

	fm_timer #(
		.WIDTH  ( TB_W         )
	) u_timer_b (
		.clk    ( clk          ),
		.reset  ( reset        ),
		.tick   ( tick_b       ),
		.load   ( cfg.load_b   ),
		.irq_en ( cfg.irq_en_b ),
		.clr    ( cfg.clr_b    ),
		.value  ( cfg.value_b  ),
		.flag   ( flag_b       )
	);

	always_comb begin
		status.busy   = busy;
		status.flag_b = flag_b;
		status.flag_a = flag_a;
	end

	// Status byte, bits 6 to 2 read as zero
	assign dout = {status.busy, 5'd0, status.flag_b, status.flag_a};

	assign irq_n = ~(flag_a | flag_b);

endmodule

/* source/fm_regs.sv */
`timescale 1ns/1ps

module fm_regs
	import fm_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cen,
	input  logic [7:0] din,
	input  logic [1:0] addr,
	input  logic       write,
	output timer_cfg_t cfg,
	output logic       clk_en,
	output logic       sample_tick,
	output logic       busy
);

	logic [7:0]        addr_latch;
	logic              bank;
	logic              addr_write;
	logic              data_write;
	logic              reg_write;
	logic [7:0]        ta_hi;
	logic [1:0]        ta_lo;
	logic [TB_W-1:0]   tb_val;
	logic              load_a;
	logic              load_b;
	logic              irq_en_a;
	logic              irq_en_b;
	logic              clr_a;
	logic              clr_b;
	logic              fast;
	logic [CEN_W-1:0]  cen_cnt;
	logic [SLOT_W-1:0] slot_cnt;
	logic              slot_step;
	logic [BUSY_W-1:0] busy_cnt;

	// addr[0] low selects the address latch, high the data port
	assign addr_write = write & ~addr[0];
	assign data_write = write & addr[0];
	// Bank 1 data is accepted but goes nowhere
	assign reg_write  = data_write & ~bank;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr_latch <= '0;
			bank       <= 1'b0;
		end else if (addr_write) begin
			addr_latch <= din;
			bank       <= addr[1];
		end
	end

	// Timer reload values
	always_ff @(posedge clk) begin
		if (reg_write) begin
			case (addr_latch)
				REG_TA_HI: ta_hi  <= din;
				REG_TA_LO: ta_lo  <= din[1:0];
				REG_TB:    tb_val <= din;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
			fast     <= 1'b0;
		end else begin
			// Clear strobes last a single cycle
			clr_a <= 1'b0;
			clr_b <= 1'b0;
			if (reg_write) begin
				case (addr_latch)
					REG_TIMER_CTL: begin
						load_a   <= din[0];
						load_b   <= din[1];
						irq_en_a <= din[2];
						irq_en_b <= din[3];
						clr_a    <= din[4];
						clr_b    <= din[5];
					end
					REG_TEST: fast <= din[2];
					default: ;
				endcase
			end
		end
	end

	// Divide cen by six
	always_ff @(posedge clk) begin
		if (reset) begin
			cen_cnt <= '0;
		end else if (cen) begin
			cen_cnt <= (cen_cnt == CEN_W'(CEN_DIV - 1)) ? '0 : cen_cnt + 1'b1;
		end
	end

	assign clk_en = cen & (cen_cnt == CEN_W'(CEN_DIV - 1));

	// Slot counter, runs on every clk in fast timer mode
	assign slot_step = fast | clk_en;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_cnt <= '0;
		end else if (slot_step) begin
			slot_cnt <= (slot_cnt == SLOT_W'(SAMPLE_DIV - 1)) ? '0 : slot_cnt + 1'b1;
		end
	end

	assign sample_tick = slot_step & (slot_cnt == SLOT_W'(SAMPLE_DIV - 1));

	// Busy restarts on every data write, any bank
	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (data_write) begin
			busy     <= 1'b1;
			busy_cnt <= BUSY_W'(BUSY_TICKS);
		end else if (busy && clk_en) begin
			busy_cnt <= busy_cnt - 1'b1;
			if (busy_cnt == BUSY_W'(1)) begin
				busy <= 1'b0;
			end
		end
	end

	always_comb begin
		cfg.value_a  = {ta_hi, ta_lo};
		cfg.value_b  = tb_val;
		cfg.load_a   = load_a;
		cfg.load_b   = load_b;
		cfg.irq_en_a = irq_en_a;
		cfg.irq_en_b = irq_en_b;
		cfg.clr_a    = clr_a;
		cfg.clr_b    = clr_b;
		cfg.fast     = fast;
	end

endmodule

/* source/fm_timer.sv */
`timescale 1ns/1ps

module fm_timer #(
	parameter int WIDTH = 10
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,
	input  logic             load,
	input  logic             irq_en,
	input  logic             clr,
	input  logic [WIDTH-1:0] value,
	output logic             flag
);

	logic [WIDTH-1:0] cnt;
	logic             load_q;
	logic             load_rise;
	logic             overflow;

	// Start of a run
	assign load_rise = load & ~load_q;

	// Counter at all ones and about to wrap
	assign overflow = load & tick & (&cnt);

	always_ff @(posedge clk) begin
		if (reset) begin
			load_q <= 1'b0;
		end else begin
			load_q <= load;
		end
	end

	// Reload has priority over counting
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (load_rise || overflow) begin
			cnt <= value;
		end else if (load && tick) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Flag holds until cleared, clear wins a tie
	always_ff @(posedge clk) begin
		if (reset) begin
			flag <= 1'b0;
		end else if (clr) begin
			flag <= 1'b0;
		end else if (overflow && irq_en) begin
			flag <= 1'b1;
		end
	end

endmodule

/* source/fm_pkg.sv */
package fm_pkg;

	// Internal enable fires on every sixth cen cycle
	localparam int CEN_DIV = 6;

	// Operator slots per sample
	localparam int SAMPLE_DIV = 24;

	// Sample ticks per timer B count
	localparam int TIMER_B_DIV = 16;

	// Internal enables that busy stays high after a data write
	localparam int BUSY_TICKS = 32;

	// Counter widths
	localparam int TA_W     = 10;
	localparam int TB_W     = 8;
	localparam int CEN_W    = $clog2(CEN_DIV);
	localparam int SLOT_W   = $clog2(SAMPLE_DIV);
	localparam int TB_DIV_W = $clog2(TIMER_B_DIV);
	localparam int BUSY_W   = $clog2(BUSY_TICKS + 1);

	// Bank 0 register map
	localparam logic [7:0] REG_TEST      = 8'h21;
	localparam logic [7:0] REG_TA_HI     = 8'h24;
	localparam logic [7:0] REG_TA_LO     = 8'h25;
	localparam logic [7:0] REG_TB        = 8'h26;
	localparam logic [7:0] REG_TIMER_CTL = 8'h27;

	typedef struct packed {
		logic [TA_W-1:0] value_a;
		logic [TB_W-1:0] value_b;
		logic            load_a;
		logic            load_b;
		logic            irq_en_a;
		logic            irq_en_b;
		logic            clr_a;
		logic            clr_b;
		logic            fast;
	} timer_cfg_t;

	// Bit order as read back on the status byte
	typedef struct packed {
		logic busy;
		logic flag_b;
		logic flag_a;
	} status_t;

endpackage
